/* files.f */
rtl/fp_mul_pkg.sv
rtl/fp_mul_if.sv
rtl/fp_mant_mul.sv
rtl/fp_norm.sv
rtl/fp_round_exp.sv
rtl/fp_mul_checker.sv
rtl/fp_mul_wb.sv
rtl/fp_mul_top.sv
testbench/fp_mul_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FP multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fp_mul_tb \
    -f files.f -Mdir obj_dir -o fp_mul_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/fp_mul_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "Run failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Run ended without a pass, see sim.log"; exit 1; }
exit 0

/* testbench/fp_mul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 16;
    localparam int NUM_VECS   = 26;
    // 200 cycles per row, plus reset and the register tests around the table
    localparam int WATCHDOG_NS = (NUM_VECS * 200 + RST_CYCLES + 200) * CLK_PERIOD;

    // One table row, flags as {zer, inf, nan, ovrf, udrf}
    typedef struct packed {
        logic [31:0] x;
        logic [31:0] y;
        logic [2:0]  mode;
        logic [31:0] z;
        logic [4:0]  flags;
    } vec_t;

    localparam vec_t VECS [NUM_VECS] = '{
        // Normal products in RNE, 3 x 3 and 1.5 x -2
        {32'h40400000, 32'h40400000, fp_mul_pkg::RNE, 32'h41100000, 5'h00},
        {32'h3fc00000, 32'hc0000000, fp_mul_pkg::RNE, 32'hc0400000, 5'h00},
        // (1 + 3 ulp) x 1.5 is an exact tie above an even lsb
        {32'h3f800003, 32'h3fc00000, fp_mul_pkg::RNE, 32'h3fc00004, 5'h00},
        {32'h3f800003, 32'h3fc00000, fp_mul_pkg::RTZ, 32'h3fc00004, 5'h00},
        {32'h3f800003, 32'h3fc00000, fp_mul_pkg::RDN, 32'h3fc00004, 5'h00},
        {32'h3f800003, 32'h3fc00000, fp_mul_pkg::RUP, 32'h3fc00005, 5'h00},
        {32'h3f800003, 32'h3fc00000, fp_mul_pkg::RMM, 32'h3fc00005, 5'h00},
        // Same tie, negative sign swaps RUP and RDN
        {32'hbf800003, 32'h3fc00000, fp_mul_pkg::RNE, 32'hbfc00004, 5'h00},
        {32'hbf800003, 32'h3fc00000, fp_mul_pkg::RTZ, 32'hbfc00004, 5'h00},
        {32'hbf800003, 32'h3fc00000, fp_mul_pkg::RDN, 32'hbfc00005, 5'h00},
        {32'hbf800003, 32'h3fc00000, fp_mul_pkg::RUP, 32'hbfc00004, 5'h00},
        {32'hbf800003, 32'h3fc00000, fp_mul_pkg::RMM, 32'hbfc00005, 5'h00},
        // (1 + ulp) squared, only sticky set below the lsb
        {32'h3f800001, 32'h3f800001, fp_mul_pkg::RUP, 32'h3f800003, 5'h00},
        {32'h3f800001, 32'h3f800001, fp_mul_pkg::RMM, 32'h3f800002, 5'h00},
        // Unused mode code rounds as RNE
        {32'h3f800003, 32'h3fc00000, 3'd5,            32'h3fc00004, 5'h00},
        // Zero and subnormal operands flush to signed zero
        {32'h00000000, 32'h40400000, fp_mul_pkg::RNE, 32'h00000000, 5'h10},
        {32'h80000000, 32'h40400000, fp_mul_pkg::RNE, 32'h80000000, 5'h10},
        {32'h00000001, 32'hc0000000, fp_mul_pkg::RNE, 32'h80000000, 5'h10},
        // 2^-126 squared underflows
        {32'h00800000, 32'h00800000, fp_mul_pkg::RNE, 32'h00000000, 5'h11},
        // Infinity operands and exponent overflow
        {32'h7f800000, 32'h40000000, fp_mul_pkg::RNE, 32'h7f800000, 5'h08},
        {32'hff800000, 32'h40000000, fp_mul_pkg::RNE, 32'hff800000, 5'h08},
        {32'h7f000000, 32'h40000000, fp_mul_pkg::RNE, 32'h7f800000, 5'h0a},
        {32'hff000000, 32'h40000000, fp_mul_pkg::RUP, 32'hff800000, 5'h0a},
        // NaN in, and inf x 0 either way round
        {32'h7fc00001, 32'h3f800000, fp_mul_pkg::RNE, 32'h7fc00000, 5'h04},
        {32'h7f800000, 32'h00000000, fp_mul_pkg::RNE, 32'h7fc00000, 5'h04},
        {32'h00000000, 32'hff800000, fp_mul_pkg::RNE, 32'h7fc00000, 5'h04}
    };

    logic        clk;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    fp_mul_top dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Ends a run that stalls on a missing ack
    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out waiting for the bus after %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0d ns %s got %08h expected %08h", $time, name, got, expected);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Sample ack just after each edge, once the flops have settled
    task automatic wait_ack();
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
    endtask

    task automatic release_bus();
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_ack();
        release_bus();
    endtask

    // Read data is taken in the ack cycle
    task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
        @(posedge clk);
        #2;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        data = wb_dat_r;
        release_bus();
    endtask

    initial begin
        logic [31:0] rd;
        arst_n   = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 3'd0;
        wb_dat_w = 32'd0;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Idle bus keeps ack low
        repeat (3) begin
            @(posedge clk);
            #1;
            check_val("wb_ack idle", {31'd0, wb_ack}, 32'd0);
        end
        // Operands reset to zero, so the registered result is +0 with only zer set
        bus_read(fp_mul_pkg::ADDR_Z, rd);
        check_val("z after reset", rd, 32'd0);
        bus_read(fp_mul_pkg::ADDR_FLAGS, rd);
        check_val("flags after reset", rd, 32'h00000010);

        for (int i = 0; i < NUM_VECS; i++) begin
            bus_write(fp_mul_pkg::ADDR_X, VECS[i].x);
            bus_write(fp_mul_pkg::ADDR_Y, VECS[i].y);
            bus_write(fp_mul_pkg::ADDR_MODE, {29'd0, VECS[i].mode});
            bus_read(fp_mul_pkg::ADDR_Z, rd);
            check_val($sformatf("z row %0d", i), rd, VECS[i].z);
            bus_read(fp_mul_pkg::ADDR_FLAGS, rd);
            check_val($sformatf("flags row %0d", i), rd, {27'd0, VECS[i].flags});
        end

        // Result and status are read only, last row must survive
        bus_write(fp_mul_pkg::ADDR_Z, 32'hdeadbeef);
        bus_write(fp_mul_pkg::ADDR_FLAGS, 32'h0000001f);
        bus_read(fp_mul_pkg::ADDR_Z, rd);
        check_val("z after write", rd, VECS[NUM_VECS-1].z);
        bus_read(fp_mul_pkg::ADDR_FLAGS, rd);
        check_val("flags after write", rd, {27'd0, VECS[NUM_VECS-1].flags});
        bus_read(fp_mul_pkg::ADDR_X, rd);
        check_val("x readback", rd, VECS[NUM_VECS-1].x);
        // Unmapped word
        bus_read(3'd7, rd);
        check_val("addr 7", rd, 32'd0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/fp_mul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    fp_mul_pkg::fp32_t     x_q, y_q, fp_z;
    fp_mul_pkg::rnd_mode_e mode_q;
    fp_mul_pkg::fp_flags_t flags;

    // Stage signals shared by the datapath and the checker
    fp_mul_if stage_if ();

    // Register file and bus side
    fp_mul_wb u_wb (
        .clk      (clk),
        .arst_n   (arst_n),
        .cyc      (wb_cyc),
        .stb      (wb_stb),
        .we       (wb_we),
        .adr      (wb_adr),
        .dat_w    (wb_dat_w),
        .dat_r    (wb_dat_r),
        .ack      (wb_ack),
        .x        (x_q),
        .y        (y_q),
        .mode     (mode_q),
        .z_in     (fp_z),
        .flags_in (flags)
    );

    // Combinational datapath, product then normalize then round
    fp_mant_mul u_mant_mul (.fp_x(x_q), .fp_y(y_q), .mul(stage_if));

    fp_norm u_norm (.mul(stage_if));

    fp_round_exp u_round_exp (.mode(mode_q), .rnd(stage_if), .fp_z(fp_z), .flags(flags));

    fp_mul_checker u_checker (
        .clk    (clk),
        .arst_n (arst_n),
        .fp_x   (x_q),
        .fp_y   (y_q),
        .fp_z   (fp_z),
        .mode   (mode_q),
        .mon    (stage_if)
    );

endmodule

`default_nettype wire

/* rtl/fp_mul_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_wb (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [2:0]            adr,
    input  logic [31:0]           dat_w,
    output logic [31:0]           dat_r,
    output logic                  ack,
    output fp_mul_pkg::fp32_t     x,
    output fp_mul_pkg::fp32_t     y,
    output fp_mul_pkg::rnd_mode_e mode,
    input  fp_mul_pkg::fp32_t     z_in,
    input  fp_mul_pkg::fp_flags_t flags_in
);

    fp_mul_pkg::fp32_t     x_q, y_q, z_q;
    fp_mul_pkg::rnd_mode_e mode_q;
    fp_mul_pkg::fp_flags_t flags_q;
    logic                  wr_en;

    // Write lands on the edge that raises ack, once per cycle
    assign wr_en = cyc & stb & we & ~ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack     <= 1'b0;
            x_q     <= '0;
            y_q     <= '0;
            mode_q  <= fp_mul_pkg::RNE;
            z_q     <= '0;
            flags_q <= '0;
        end else begin
            // Held while stb stays high, drops the cycle after
            ack     <= cyc & stb;
            // Result follows the operands one edge later
            z_q     <= z_in;
            flags_q <= flags_in;
            if (wr_en) begin
                case (adr)
                    fp_mul_pkg::ADDR_X:    x_q    <= dat_w;
                    fp_mul_pkg::ADDR_Y:    y_q    <= dat_w;
                    fp_mul_pkg::ADDR_MODE: mode_q <= fp_mul_pkg::rnd_mode_e'(dat_w[2:0]);
                    // Result and status are read only
                    default: ;
                endcase
            end
        end
    end

    // Read mux, unmapped words read as zero
    always_comb begin
        case (adr)
            fp_mul_pkg::ADDR_X:     dat_r = x_q;
            fp_mul_pkg::ADDR_Y:     dat_r = y_q;
            fp_mul_pkg::ADDR_MODE:  dat_r = {29'd0, mode_q};
            fp_mul_pkg::ADDR_Z:     dat_r = z_q;
            fp_mul_pkg::ADDR_FLAGS: dat_r = {27'd0, flags_q};
            default:                dat_r = 32'd0;
        endcase
    end

    assign x    = x_q;
    assign y    = y_q;
    assign mode = mode_q;

endmodule

`default_nettype wire

/* rtl/fp_mul_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_mul_checker (
    input  logic                  clk,
    input  logic                  arst_n,
    input  fp_mul_pkg::fp32_t     fp_x,
    input  fp_mul_pkg::fp32_t     fp_y,
    input  fp_mul_pkg::fp32_t     fp_z,
    input  fp_mul_pkg::rnd_mode_e mode,
    fp_mul_if.monitor             mon
);

    // Classes as {sub, inf, nan, zer}
    logic [3:0]        x_cls, y_cls;
    logic              ops_normal;
    logic [47:0]       prod_ref, shift_ref;
    logic              g, s, inexact;
    logic [23:0]       base, rne_r, rdn_r, rup_r, rmm_r;
    logic signed [9:0] sum_ref, exp_ref;
    logic              ovrf_ref, udrf_ref, nan_ref, inf_ref, zer_ref;

    always_comb begin
        x_cls = {~|fp_x.exp & |fp_x.frc, &fp_x.exp & ~|fp_x.frc,
                 &fp_x.exp & |fp_x.frc, ~|fp_x.exp & ~|fp_x.frc};
        y_cls = {~|fp_y.exp & |fp_y.frc, &fp_y.exp & ~|fp_y.frc,
                 &fp_y.exp & |fp_y.frc, ~|fp_y.exp & ~|fp_y.frc};
        ops_normal = ~|x_cls & ~|y_cls;
        prod_ref  = {1'b1, fp_x.frc} * {1'b1, fp_y.frc};
        shift_ref = mon.frc_z_full[47] ? mon.frc_z_full : {mon.frc_z_full[46:0], 1'b0};
        // Candidate roundings built from the normalized stage
        g       = mon.frc_z_norm[2];
        s       = |mon.frc_z_norm[1:0];
        inexact = g | s;
        base    = {1'b0, mon.frc_z_norm[25:3]};
        rne_r   = base + {23'd0, g & (s | mon.frc_z_norm[3])};
        rdn_r   = base + {23'd0, inexact & mon.sign_z};
        rup_r   = base + {23'd0, inexact & ~mon.sign_z};
        rmm_r   = base + {23'd0, g};
        sum_ref = $signed({2'b00, fp_x.exp}) + $signed({2'b00, fp_y.exp});
        exp_ref = sum_ref - fp_mul_pkg::EXP_BIAS
                + $signed({9'd0, mon.norm_n}) + $signed({9'd0, mon.norm_r});
        ovrf_ref = ops_normal & (exp_ref >= 10'sd255);
        udrf_ref = ops_normal & (exp_ref <= 10'sd0);
        nan_ref  = x_cls[1] | y_cls[1] | (x_cls[2] & (y_cls[3] | y_cls[0]))
                 | (y_cls[2] & (x_cls[3] | x_cls[0]));
        inf_ref  = ~nan_ref & (x_cls[2] | y_cls[2] | ovrf_ref);
        zer_ref  = ~nan_ref & ~inf_ref & (x_cls[3] | x_cls[0] | y_cls[3] | y_cls[0] | udrf_ref);
    end

    default clocking cb @(posedge clk); endclocking
    default disable iff (!arst_n);

    // Product stage
    a_class:   assert property ({mon.x_sub, mon.x_inf, mon.x_nan, mon.x_zer,
                                 mon.y_sub, mon.y_inf, mon.y_nan, mon.y_zer} == {x_cls, y_cls});
    a_full:    assert property (mon.frc_z_full == prod_ref);
    a_sign:    assert property (mon.sign_z == (fp_x.sign ^ fp_y.sign));
    // Normalization and sticky
    a_norm:    assert property (mon.norm_n == mon.frc_z_full[47] &&
                                mon.frc_z_norm == {shift_ref[47:22], |shift_ref[21:0]});
    a_lead:    assert property (ops_normal |-> mon.frc_z_norm[26]);
    // One check per rounding mode, carry included
    a_rne:     assert property ((mode == fp_mul_pkg::RNE || mode > fp_mul_pkg::RMM)
                                |-> {mon.norm_r, mon.frc_z} == rne_r);
    a_rtz:     assert property (mode == fp_mul_pkg::RTZ |-> {mon.norm_r, mon.frc_z} == base);
    a_rdn:     assert property (mode == fp_mul_pkg::RDN |-> {mon.norm_r, mon.frc_z} == rdn_r);
    a_rup:     assert property (mode == fp_mul_pkg::RUP |-> {mon.norm_r, mon.frc_z} == rup_r);
    a_rmm:     assert property (mode == fp_mul_pkg::RMM |-> {mon.norm_r, mon.frc_z} == rmm_r);
    // Exponent equation
    a_exp:     assert property (mon.exp_sum == sum_ref && mon.exp_z == exp_ref[7:0]);
    // Exceptions
    a_flags:   assert property (mon.flags == {zer_ref, inf_ref, nan_ref, ovrf_ref, udrf_ref});
    // Packing of the result
    a_pk_nan:  assert property (mon.flags.nan |-> fp_z == fp_mul_pkg::QNAN);
    a_pk_inf:  assert property (mon.flags.inf |-> fp_z == {mon.sign_z, 8'hff, 23'd0});
    a_pk_zer:  assert property (mon.flags.zer |-> fp_z == {mon.sign_z, 31'd0});
    a_pk_norm: assert property (!(mon.flags.nan || mon.flags.inf || mon.flags.zer)
                                |-> fp_z == {mon.sign_z, mon.exp_z, mon.frc_z});

endmodule

`default_nettype wire

/* rtl/fp_round_exp.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_round_exp (
    input  fp_mul_pkg::rnd_mode_e mode,
    fp_mul_if.rnd                 rnd,
    output fp_mul_pkg::fp32_t     fp_z,
    output fp_mul_pkg::fp_flags_t flags
);

    logic              lsb, guard, sticky, inexact;
    logic              inc;
    logic              ops_normal;
    logic signed [9:0] exp_full;
    fp_mul_pkg::fp_flags_t flg;

    // lsb of the kept fraction, guard below it, rest is sticky
    assign lsb     = rnd.frc_z_norm[3];
    assign guard   = rnd.frc_z_norm[2];
    assign sticky  = |rnd.frc_z_norm[1:0];
    assign inexact = guard | sticky;

    always_comb begin
        case (mode)
            fp_mul_pkg::RTZ: inc = 1'b0;
            // Directed modes bump only when moving away from zero
            fp_mul_pkg::RDN: inc = inexact & rnd.sign_z;
            fp_mul_pkg::RUP: inc = inexact & ~rnd.sign_z;
            // Ties away from zero
            fp_mul_pkg::RMM: inc = guard;
            // RNE and the unused codes, ties go to even
            default:         inc = guard & (sticky | lsb);
        endcase
    end

    // Carry out means 1.11..1 rolled over to 10.0, fraction wraps to zero
    assign {rnd.norm_r, rnd.frc_z} = {1'b0, rnd.frc_z_norm[25:3]} + {23'd0, inc};

    assign exp_full = rnd.exp_sum - fp_mul_pkg::EXP_BIAS
                    + $signed({9'd0, rnd.norm_n}) + $signed({9'd0, rnd.norm_r});
    assign rnd.exp_z = exp_full[7:0];

    // Range flags only make sense when both operands are normal
    assign ops_normal = ~(rnd.x_sub | rnd.x_inf | rnd.x_nan | rnd.x_zer)
                      & ~(rnd.y_sub | rnd.y_inf | rnd.y_nan | rnd.y_zer);

    always_comb begin
        flg.ovrf = ops_normal & (exp_full >= 10'sd255);
        flg.udrf = ops_normal & (exp_full <= 10'sd0);
        // NaN in, or inf times a zero (subnormals count as zero)
        flg.nan  = rnd.x_nan | rnd.y_nan
                 | (rnd.x_inf & (rnd.y_zer | rnd.y_sub))
                 | (rnd.y_inf & (rnd.x_zer | rnd.x_sub));
        flg.inf  = ~flg.nan & (rnd.x_inf | rnd.y_inf | flg.ovrf);
        flg.zer  = ~flg.nan & ~flg.inf
                 & (rnd.x_zer | rnd.x_sub | rnd.y_zer | rnd.y_sub | flg.udrf);
    end

    assign flags     = flg;
    assign rnd.flags = flg;

    // Pack by priority NaN, inf, zero, normal
    always_comb begin
        if (flg.nan) begin
            fp_z = fp_mul_pkg::QNAN;
        end else if (flg.inf) begin
            fp_z = {rnd.sign_z, 8'hff, 23'd0};
        end else if (flg.zer) begin
            fp_z = {rnd.sign_z, 31'd0};
        end else begin
            fp_z = {rnd.sign_z, rnd.exp_z, rnd.frc_z};
        end
    end

endmodule

`default_nettype wire

/* rtl/fp_norm.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_norm (
    fp_mul_if.norm mul
);

    logic [47:0] frc_shift;

    // Product of two 1.x mantissas lies in [1, 4)
    // Bit 47 set means the product is 2 or more and stays put
    assign mul.norm_n = mul.frc_z_full[47];

    always_comb begin
        if (mul.frc_z_full[47]) begin
            frc_shift = mul.frc_z_full;
        end else begin
            frc_shift = {mul.frc_z_full[46:0], 1'b0};
        end
    end

    // Leading one, 23 fraction bits, guard, round bit
    // Everything below collapses into sticky
    assign mul.frc_z_norm = {frc_shift[47:22], |frc_shift[21:0]};

endmodule

`default_nettype wire

/* rtl/fp_mant_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_mant_mul (
    input  fp_mul_pkg::fp32_t fp_x,
    input  fp_mul_pkg::fp32_t fp_y,
    fp_mul_if.mul             mul
);

    logic x_exp_max, y_exp_max;
    logic x_exp_min, y_exp_min;
    logic x_frc_nz, y_frc_nz;

    // Exponent all ones marks inf or NaN, all zeros marks zero or subnormal
    assign x_exp_max = &fp_x.exp;
    assign y_exp_max = &fp_y.exp;
    assign x_exp_min = ~|fp_x.exp;
    assign y_exp_min = ~|fp_y.exp;
    assign x_frc_nz  = |fp_x.frc;
    assign y_frc_nz  = |fp_y.frc;

    // Operand classes
    assign mul.x_zer = x_exp_min & ~x_frc_nz;
    assign mul.x_sub = x_exp_min & x_frc_nz;
    assign mul.x_inf = x_exp_max & ~x_frc_nz;
    assign mul.x_nan = x_exp_max & x_frc_nz;
    assign mul.y_zer = y_exp_min & ~y_frc_nz;
    assign mul.y_sub = y_exp_min & y_frc_nz;
    assign mul.y_inf = y_exp_max & ~y_frc_nz;
    assign mul.y_nan = y_exp_max & y_frc_nz;

    assign mul.sign_z = fp_x.sign ^ fp_y.sign;

    // Biased sum, range 0 to 510
    assign mul.exp_sum = $signed({2'b00, fp_x.exp}) + $signed({2'b00, fp_y.exp});

    // Hidden one always set, subnormals are flushed later
    assign mul.frc_z_full = {1'b1, fp_x.frc} * {1'b1, fp_y.frc};

endmodule

`default_nettype wire

/* rtl/fp_mul_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fp_mul_if;

    // Operand classes from the product stage
    logic x_sub, x_inf, x_nan, x_zer;
    logic y_sub, y_inf, y_nan, y_zer;
    logic                  sign_z;
    // Sum of the biased exponents, bias not yet removed
    logic signed [9:0]     exp_sum;
    logic [47:0]           frc_z_full;
    // Normalized mantissa with guard and sticky
    logic [26:0]           frc_z_norm;
    logic                  norm_n;
    // Rounded fields and exceptions
    logic [22:0]           frc_z;
    logic                  norm_r;
    logic [7:0]            exp_z;
    fp_mul_pkg::fp_flags_t flags;

    modport mul (
        output x_sub, x_inf, x_nan, x_zer, y_sub, y_inf, y_nan, y_zer,
        output sign_z, exp_sum, frc_z_full
    );

    modport norm (input frc_z_full, output frc_z_norm, norm_n);

    modport rnd (
        input  x_sub, x_inf, x_nan, x_zer, y_sub, y_inf, y_nan, y_zer,
        input  sign_z, exp_sum, frc_z_norm, norm_n,
        output frc_z, norm_r, exp_z, flags
    );

    modport monitor (
        input x_sub, x_inf, x_nan, x_zer, y_sub, y_inf, y_nan, y_zer,
        input sign_z, exp_sum, frc_z_full, frc_z_norm, norm_n,
        input frc_z, norm_r, exp_z, flags
    );

endinterface

`default_nettype wire

/* rtl/fp_mul_pkg.sv */
`default_nettype none

package fp_mul_pkg;

    // IEEE 754 single precision word
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frc;
    } fp32_t;

    // Rounding modes, codes 5 to 7 fall back to RNE
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } rnd_mode_e;

    // Exception flags as seen at the status register, zer is bit 4
    typedef struct packed {
        logic zer;
        logic inf;
        logic nan;
        logic ovrf;
        logic udrf;
    } fp_flags_t;

    // Word addresses on the bus
    localparam logic [2:0] ADDR_X     = 3'd0;
    localparam logic [2:0] ADDR_Y     = 3'd1;
    localparam logic [2:0] ADDR_MODE  = 3'd2;
    localparam logic [2:0] ADDR_Z     = 3'd3;
    localparam logic [2:0] ADDR_FLAGS = 3'd4;

    localparam logic signed [9:0] EXP_BIAS = 10'sd127;
    // Canonical quiet NaN
    localparam logic [31:0] QNAN = 32'h7fc00000;

endpackage

`default_nettype wire
